// ==== rtl/accel_regs_pkg.sv ====
`default_nettype none

package accel_regs_pkg;

  // core register port
  localparam int IO_DATA_W = 32;
  localparam int IO_STRB_W = IO_DATA_W / 8;
  localparam int IO_ADDR_W = 22;

  // register offsets are decoded from io addr bits 6..2
  localparam int REG_OFF_W = 7;

  typedef struct packed {
    logic                 en;
    logic                 wen;
    logic [IO_STRB_W-1:0] strb;
    logic [IO_ADDR_W-1:0] addr;
    logic [IO_DATA_W-1:0] wr_data;
  } mmio_req_t;

  typedef struct packed {
    logic [IO_DATA_W-1:0] rd_data;
    logic                 rd_valid;
  } mmio_rsp_t;

  // job command and readback block
  localparam logic [REG_OFF_W-1:0] REG_CTRL     = 7'h00;
  localparam logic [REG_OFF_W-1:0] REG_LEN      = 7'h04;
  localparam logic [REG_OFF_W-1:0] REG_ADDR     = 7'h08;
  localparam logic [REG_OFF_W-1:0] REG_PORTS    = 7'h0C;
  localparam logic [REG_OFF_W-1:0] REG_STATE_LO = 7'h10;
  localparam logic [REG_OFF_W-1:0] REG_STATE_HI = 7'h14;
  localparam logic [REG_OFF_W-1:0] REG_SLOT     = 7'h18;
  localparam logic [REG_OFF_W-1:0] REG_RULE     = 7'h1C;

  // flow-table line words live at 0x40..0x5C
  localparam logic [REG_OFF_W-1:0] FLOW_WORDS    = 7'h40;
  localparam logic [REG_OFF_W-1:0] REG_FLOW_REQ  = 7'h60;
  localparam logic [REG_OFF_W-1:0] REG_FLOW_MODE = 7'h64;
  localparam logic [REG_OFF_W-1:0] REG_STATUS    = 7'h78;

  // control word bits
  localparam int CTRL_START   = 0;
  localparam int CTRL_RELEASE = 1;
  localparam int CTRL_STOP    = 2;

  // status word bits
  localparam int ST_BUSY = 0;
  localparam int ST_DONE = 8;
  localparam int ST_ERR  = 16;

endpackage

`default_nettype wire

// ==== rtl/accel_data_pkg.sv ====
`default_nettype none

package accel_data_pkg;

  // hash-table memory geometry
  localparam int DATA_W      = 128;
  localparam int FLOW_LINE_W = 2 * DATA_W;
  localparam int HASH_BLOCKS = 4;
  localparam int BLOCK_SEL_W = 2;
  localparam int MEM_ADDR_W  = 12;

  // job descriptor widths
  localparam int LEN_W       = 14;
  localparam int DESC_ADDR_W = 24;

  // 16 entries per command FIFO
  localparam int FIFO_DEPTH_LOG2 = 4;

  typedef struct packed {
    logic [DESC_ADDR_W-1:0] addr;
    logic [LEN_W-1:0]       len;
  } desc_t;

  typedef struct packed {
    logic [63:0] preamble;
    logic [15:0] dst_port;
    logic [15:0] src_port;
  } meta_t;

  typedef logic [7:0]  slot_t;
  typedef logic [63:0] state_t;

  // pattern matcher result
  typedef struct packed {
    logic        valid;
    logic        last;
    logic [31:0] rule_id;
  } match_t;

  typedef struct packed {
    logic                   valid;
    logic [MEM_ADDR_W-1:0]  addr;
    logic [BLOCK_SEL_W-1:0] block;
    logic                   bank;
  } flow_req_t;

  // shared by every block and both banks
  typedef struct packed {
    logic                  en;
    logic [MEM_ADDR_W-1:0] addr;
  } mem_req_t;

  typedef logic [DATA_W-1:0] mem_line_t;

endpackage

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_fifo
  import accel_data_pkg::*;
#(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output logic     valid,
  output payload_t dout
);

  payload_t mem [2**FIFO_DEPTH_LOG2];

  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [FIFO_DEPTH_LOG2:0]   count;
  logic                       full;
  logic                       do_push;
  logic                       do_pop;

  assign full    = count[FIFO_DEPTH_LOG2];
  assign valid   = (count != '0);
  assign do_push = push && !full;
  assign do_pop  = pop && valid;

  // head is always visible
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mmio_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module mmio_regs
  import accel_regs_pkg::*;
  import accel_data_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  mmio_req_t              bus,
  output mmio_rsp_t              rsp,
  output logic                   start,
  output logic                   stop,
  output logic                   match_release,
  output desc_t                  desc,
  output meta_t                  meta,
  output slot_t                  slot,
  output flow_req_t              flow_req,
  input  logic [FLOW_LINE_W-1:0] flow_line,
  input  logic                   flow_ready,
  input  match_t                 match,
  input  state_t                 state_head,
  input  logic                   state_valid_head,
  input  slot_t                  slot_head,
  input  logic                   done,
  input  logic                   err,
  input  logic                   desc_ready
);

  logic [REG_OFF_W-1:0] offset;
  logic [IO_DATA_W-1:0] flow_word;
  logic [IO_DATA_W-1:0] rd_data;
  logic                 rd_valid;
  logic                 stall;
  logic                 mode_32b;

  assign offset    = {bus.addr[6:2], 2'b00};
  assign flow_word = flow_line[bus.addr[4:2]*IO_DATA_W +: IO_DATA_W];

  assign rsp.rd_data  = rd_data;
  assign rsp.rd_valid = rd_valid;

  always_ff @(posedge clk) begin
    // one-cycle strobes
    start          <= 1'b0;
    stop           <= 1'b0;
    match_release  <= 1'b0;
    flow_req.valid <= 1'b0;
    rd_valid       <= 1'b0;

    if (bus.en && bus.wen) begin
      case (offset)
        REG_CTRL: begin
          if (bus.strb[0]) begin
            start         <= bus.wr_data[CTRL_START];
            match_release <= bus.wr_data[CTRL_RELEASE];
            stop          <= bus.wr_data[CTRL_STOP];
          end
        end
        REG_LEN:      desc.len  <= bus.wr_data[LEN_W-1:0];
        REG_ADDR:     desc.addr <= bus.wr_data[DESC_ADDR_W-1:0];
        REG_PORTS: begin
          // only whole halfwords are written
          if (bus.strb[1] && bus.strb[0]) begin
            meta.src_port <= bus.wr_data[15:0];
          end
          if (bus.strb[3] && bus.strb[2]) begin
            meta.dst_port <= bus.wr_data[31:16];
          end
        end
        REG_STATE_LO: meta.preamble[31:0]  <= bus.wr_data;
        REG_STATE_HI: meta.preamble[63:32] <= bus.wr_data;
        REG_SLOT:     slot <= bus.wr_data[7:0];
        REG_FLOW_REQ: begin
          flow_req.valid <= 1'b1;
          if (mode_32b) begin
            flow_req.addr  <= bus.wr_data[MEM_ADDR_W-1:0];
            flow_req.block <= bus.wr_data[MEM_ADDR_W +: BLOCK_SEL_W];
            flow_req.bank  <= 1'b0;
          end else begin
            // 16B mode, bit 0 picks the bank
            flow_req.addr  <= bus.wr_data[MEM_ADDR_W:1];
            flow_req.block <= bus.wr_data[MEM_ADDR_W+1 +: BLOCK_SEL_W];
            flow_req.bank  <= bus.wr_data[0];
          end
        end
        REG_FLOW_MODE: begin
          if (bus.strb[0]) begin
            mode_32b <= bus.wr_data[0];
          end
        end
        default: ;
      endcase
    end

    if (bus.en && !bus.wen && !stall) begin
      rd_data  <= '0;
      rd_valid <= 1'b1;
      if ({bus.addr[6:5], 5'd0} == FLOW_WORDS) begin
        // wait for the line if a request is still in flight
        rd_data  <= flow_word;
        rd_valid <= flow_ready && !flow_req.valid;
        stall    <= !flow_ready || flow_req.valid;
      end else begin
        case (offset)
          REG_CTRL: begin
            rd_data[0] <= match.valid;
            rd_valid   <= !match_release;
            stall      <= match_release;
          end
          REG_LEN:       rd_data <= IO_DATA_W'(desc.len);
          REG_ADDR:      rd_data <= IO_DATA_W'(desc.addr);
          REG_PORTS:     rd_data <= {meta.dst_port, meta.src_port};
          REG_STATE_LO:  rd_data <= state_head[31:0];
          REG_STATE_HI:  rd_data <= state_head[63:32];
          REG_SLOT:      rd_data <= IO_DATA_W'({state_valid_head, slot_head});
          REG_RULE:      rd_data <= match.rule_id;
          REG_FLOW_MODE: rd_data <= IO_DATA_W'(mode_32b);
          REG_STATUS: begin
            rd_data[ST_BUSY] <= !desc_ready;
            rd_data[ST_DONE] <= done;
            rd_data[ST_ERR]  <= err;
          end
          default: ;
        endcase
      end
    end else if (stall) begin
      // core holds the address while stalled
      if (!bus.addr[6]) begin
        rd_data  <= IO_DATA_W'(match.valid);
        rd_valid <= 1'b1;
        stall    <= 1'b0;
      end else begin
        rd_data  <= flow_word;
        rd_valid <= flow_ready;
        stall    <= !flow_ready;
      end
    end

    if (rst) begin
      start                <= 1'b0;
      stop                 <= 1'b0;
      match_release        <= 1'b0;
      flow_req.valid       <= 1'b0;
      mode_32b             <= 1'b0;
      rd_valid             <= 1'b0;
      stall                <= 1'b0;
      // initial preamble state
      meta.preamble[63:56] <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/job_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module job_queue
  import accel_data_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   start,
  input  logic   stop,
  input  logic   match_release,
  input  desc_t  desc,
  input  meta_t  meta,
  input  slot_t  slot,
  output desc_t  desc_out,
  output logic   desc_valid,
  input  logic   desc_ready,
  output meta_t  meta_out,
  output logic   meta_valid,
  input  logic   meta_ready,
  input  logic   match_last,
  input  state_t state_in,
  input  logic   state_in_valid,
  output slot_t  slot_head,
  output state_t state_head,
  output logic   state_valid_head,
  input  logic   accel_done,
  output logic   done,
  output logic   err
);

  logic result_pop;

  // slot and state retire together at the end of a match
  assign result_pop = match_release && match_last;

  sync_fifo #(.payload_t(desc_t)) desc_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (start),
    .din   (desc),
    .pop   (desc_ready),
    .valid (desc_valid),
    .dout  (desc_out)
  );

  sync_fifo #(.payload_t(meta_t)) meta_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (start),
    .din   (meta),
    .pop   (meta_ready),
    .valid (meta_valid),
    .dout  (meta_out)
  );

  sync_fifo #(.payload_t(slot_t)) slot_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (start),
    .din   (slot),
    .pop   (result_pop),
    .valid (),
    .dout  (slot_head)
  );

  sync_fifo #(.payload_t(state_t)) state_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (state_in_valid),
    .din   (state_in),
    .pop   (result_pop),
    .valid (state_valid_head),
    .dout  (state_head)
  );

  // sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
      err  <= 1'b0;
    end else begin
      done <= done || accel_done || stop;
      // done while the DMA side still holds a descriptor
      err  <= err || (done && !desc_ready);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/flow_table_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

module flow_table_reader
  import accel_data_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  flow_req_t                    flow_req,
  output mem_req_t                     mem_req,
  input  mem_line_t [HASH_BLOCKS-1:0]  rd_b1,
  input  mem_line_t [HASH_BLOCKS-1:0]  rd_b2,
  output logic [FLOW_LINE_W-1:0]       flow_line,
  output logic                         flow_ready
);

  // stage 0 drives the memory, stage 2 meets the returned data
  logic [2:0]             vld_pipe;
  logic [2:0]             bank_pipe;
  logic [BLOCK_SEL_W-1:0] blk_pipe [3];
  logic [MEM_ADDR_W-1:0]  addr_q;
  mem_line_t              line_b1;
  mem_line_t              line_b2;

  assign mem_req.en   = vld_pipe[0];
  assign mem_req.addr = addr_q;

  assign line_b1 = rd_b1[blk_pipe[2]];
  assign line_b2 = rd_b2[blk_pipe[2]];

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe   <= '0;
      flow_ready <= 1'b0;
    end else begin
      vld_pipe   <= {vld_pipe[1:0], flow_req.valid};
      // held until the next request arrives
      flow_ready <= vld_pipe[2] || (flow_ready && !flow_req.valid);
    end
  end

  always_ff @(posedge clk) begin
    addr_q      <= flow_req.addr;
    bank_pipe   <= {bank_pipe[1:0], flow_req.bank};
    blk_pipe[0] <= flow_req.block;
    blk_pipe[1] <= blk_pipe[0];
    blk_pipe[2] <= blk_pipe[1];
    if (vld_pipe[2]) begin
      // requested bank goes to the upper half
      flow_line <= bank_pipe[2] ? {line_b1, line_b2} : {line_b2, line_b1};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/accel_wrap.sv ====
`timescale 1ns/1ns
`default_nettype none

module accel_wrap
  import accel_regs_pkg::*;
  import accel_data_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  mmio_req_t                   bus,
  output mmio_rsp_t                   rsp,
  output mem_req_t                    mem_req,
  input  mem_line_t [HASH_BLOCKS-1:0] rd_b1,
  input  mem_line_t [HASH_BLOCKS-1:0] rd_b2,
  output desc_t                       desc_out,
  output logic                        desc_valid,
  input  logic                        desc_ready,
  output meta_t                       meta_out,
  output logic                        meta_valid,
  input  logic                        meta_ready,
  input  match_t                      match,
  output logic                        match_release,
  input  state_t                      state_in,
  input  logic                        state_in_valid,
  input  logic                        accel_done
);

  logic                   start;
  logic                   stop;
  desc_t                  desc;
  meta_t                  meta;
  slot_t                  slot;
  flow_req_t              flow_req;
  logic [FLOW_LINE_W-1:0] flow_line;
  logic                   flow_ready;
  state_t                 state_head;
  logic                   state_valid_head;
  slot_t                  slot_head;
  logic                   done;
  logic                   err;

  mmio_regs u_regs (
    .clk              (clk),
    .rst              (rst),
    .bus              (bus),
    .rsp              (rsp),
    .start            (start),
    .stop             (stop),
    .match_release    (match_release),
    .desc             (desc),
    .meta             (meta),
    .slot             (slot),
    .flow_req         (flow_req),
    .flow_line        (flow_line),
    .flow_ready       (flow_ready),
    .match            (match),
    .state_head       (state_head),
    .state_valid_head (state_valid_head),
    .slot_head        (slot_head),
    .done             (done),
    .err              (err),
    .desc_ready       (desc_ready)
  );

  job_queue u_queue (
    .clk              (clk),
    .rst              (rst),
    .start            (start),
    .stop             (stop),
    .match_release    (match_release),
    .desc             (desc),
    .meta             (meta),
    .slot             (slot),
    .desc_out         (desc_out),
    .desc_valid       (desc_valid),
    .desc_ready       (desc_ready),
    .meta_out         (meta_out),
    .meta_valid       (meta_valid),
    .meta_ready       (meta_ready),
    .match_last       (match.last),
    .state_in         (state_in),
    .state_in_valid   (state_in_valid),
    .slot_head        (slot_head),
    .state_head       (state_head),
    .state_valid_head (state_valid_head),
    .accel_done       (accel_done),
    .done             (done),
    .err              (err)
  );

  flow_table_reader u_flow (
    .clk        (clk),
    .rst        (rst),
    .flow_req   (flow_req),
    .mem_req    (mem_req),
    .rd_b1      (rd_b1),
    .rd_b2      (rd_b2),
    .flow_line  (flow_line),
    .flow_ready (flow_ready)
  );

endmodule

`default_nettype wire

// ==== verification/accel_wrap_tests.svh ====
`ifndef ACCEL_WRAP_TESTS_SVH
`define ACCEL_WRAP_TESTS_SVH

task automatic test_reset_readback();
  logic [IO_DATA_W-1:0] len_v;
  logic [IO_DATA_W-1:0] addr_v;
  logic [IO_DATA_W-1:0] new_v;
  logic [IO_DATA_W-1:0] exp_ports;
  logic [IO_STRB_W-1:0] strb_list [5] = '{4'b0011, 4'b1100, 4'b0110, 4'b1000, 4'b1111};
  read_check("flow_mode", REG_FLOW_MODE, '0);
  // busy while desc_ready is low
  read_check("status", REG_STATUS, IO_DATA_W'(1) << ST_BUSY);
  len_v     = $random(seed);
  addr_v    = $random(seed);
  exp_ports = $random(seed);
  bus_write(REG_LEN, len_v, 4'hf);
  bus_write(REG_ADDR, addr_v, 4'hf);
  bus_write(REG_PORTS, exp_ports, 4'hf);
  read_check("len", REG_LEN, IO_DATA_W'(len_v[LEN_W-1:0]));
  read_check("addr", REG_ADDR, IO_DATA_W'(addr_v[DESC_ADDR_W-1:0]));
  read_check("ports", REG_PORTS, exp_ports);
  foreach (strb_list[i]) begin
    new_v = $random(seed);
    bus_write(REG_PORTS, new_v, strb_list[i]);
    if (&strb_list[i][1:0]) exp_ports[15:0] = new_v[15:0];
    if (&strb_list[i][3:2]) exp_ports[31:16] = new_v[31:16];
    read_check("ports", REG_PORTS, exp_ports);
  end
endtask

task automatic write_job(desc_t d, meta_t m, slot_t s);
  bus_write(REG_LEN, IO_DATA_W'(d.len), 4'hf);
  bus_write(REG_ADDR, IO_DATA_W'(d.addr), 4'hf);
  bus_write(REG_PORTS, {m.dst_port, m.src_port}, 4'hf);
  bus_write(REG_STATE_LO, m.preamble[31:0], 4'hf);
  bus_write(REG_STATE_HI, m.preamble[63:32], 4'hf);
  bus_write(REG_SLOT, IO_DATA_W'(s), 4'hf);
  bus_write(REG_CTRL, IO_DATA_W'(1) << CTRL_START, 4'hf);
endtask

task automatic test_command_queue();
  desc_t job_desc [2];
  meta_t job_meta [2];
  int    waited;
  for (int j = 0; j < 2; j++) begin
    job_desc[j].len  = LEN_W'($random(seed));
    job_desc[j].addr = DESC_ADDR_W'($random(seed));
    job_meta[j]      = {$random(seed), $random(seed), $random(seed)};
    queued_slot[j]   = slot_t'($random(seed));
    write_job(job_desc[j], job_meta[j], queued_slot[j]);
  end
  waited = 0;
  while (!desc_valid && waited < WAIT_LIMIT) begin
    next_cycle();
    waited++;
  end
  if (!desc_valid) fail_now("desc_valid did not rise after start");
  for (int j = 0; j < 2; j++) begin
    check_word("meta_valid", IO_DATA_W'(meta_valid), 1);
    check_desc(desc_out, job_desc[j]);
    check_meta(meta_out, job_meta[j]);
    // one ready pulse pops one job
    desc_ready = 1'b1;
    meta_ready = 1'b1;
    next_cycle();
    desc_ready = 1'b0;
    meta_ready = 1'b0;
  end
  check_word("desc_valid", IO_DATA_W'(desc_valid), 0);
  check_word("meta_valid", IO_DATA_W'(meta_valid), 0);
endtask

task automatic test_match_release();
  state_t               st [2];
  logic [IO_DATA_W-1:0] rule;
  rule          = $random(seed);
  match.valid   = 1'b1;
  match.last    = 1'b0;
  match.rule_id = rule;
  read_check("rule_id", REG_RULE, rule);
  read_check("match_valid", REG_CTRL, 1);
  for (int k = 0; k < 2; k++) begin
    st[k]          = {$random(seed), $random(seed)};
    state_in       = st[k];
    state_in_valid = 1'b1;
    next_cycle();
    state_in_valid = 1'b0;
  end
  read_check("state_lo", REG_STATE_LO, st[0][31:0]);
  read_check("state_hi", REG_STATE_HI, st[0][63:32]);
  read_check("slot", REG_SLOT, IO_DATA_W'({1'b1, queued_slot[0]}));
  // without last nothing retires
  bus_write(REG_CTRL, IO_DATA_W'(1) << CTRL_RELEASE, 4'hf);
  check_word("match_release", IO_DATA_W'(match_release), 1);
  read_check("match_valid", REG_CTRL, 1);
  // a release just before the read holds it back one cycle
  if (read_cycles != 2) fail_now("match status read after release did not stall one cycle");
  check_word("match_release", IO_DATA_W'(match_release), 0);
  read_check("slot", REG_SLOT, IO_DATA_W'({1'b1, queued_slot[0]}));
  match.last = 1'b1;
  bus_write(REG_CTRL, IO_DATA_W'(1) << CTRL_RELEASE, 4'hf);
  check_word("match_release", IO_DATA_W'(match_release), 1);
  read_check("match_valid", REG_CTRL, 1);
  read_check("slot", REG_SLOT, IO_DATA_W'({1'b1, queued_slot[1]}));
  read_check("state_lo", REG_STATE_LO, st[1][31:0]);
  read_check("state_hi", REG_STATE_HI, st[1][63:32]);
  match = '0;
endtask

task automatic flow_case(logic mode32, logic bank);
  logic [MEM_ADDR_W-1:0]  addr_v;
  logic [BLOCK_SEL_W-1:0] blk;
  logic [IO_DATA_W-1:0]   req;
  logic [IO_DATA_W-1:0]   got;
  addr_v = MEM_ADDR_W'($random(seed));
  blk    = BLOCK_SEL_W'($random(seed));
  req    = mode32 ? IO_DATA_W'({blk, addr_v}) : IO_DATA_W'({blk, addr_v, bank});
  bus_write(REG_FLOW_REQ, req, 4'hf);
  for (int i = 0; i < 8; i++) begin
    bus_read(REG_OFF_W'(int'(FLOW_WORDS) + 4 * i), got);
    if (i == 0 && read_cycles < 2) fail_now("flow word read did not wait for the line");
    check_word($sformatf("flow_word[%0d]", i), got,
               expected_flow_word(mode32 ? 1'b0 : bank, blk, addr_v, i));
  end
endtask

task automatic test_flow_reads();
  flow_case(1'b0, 1'b0);
  flow_case(1'b0, 1'b1);
  bus_write(REG_FLOW_MODE, 1, 4'hf);
  read_check("flow_mode", REG_FLOW_MODE, 1);
  flow_case(1'b1, 1'b0);
endtask

task automatic test_status();
  desc_ready = 1'b1;
  read_check("status", REG_STATUS, '0);
  accel_done = 1'b1;
  next_cycle();
  accel_done = 1'b0;
  read_check("status", REG_STATUS, IO_DATA_W'(1) << ST_DONE);
  // done with desc_ready low raises err a cycle later
  desc_ready = 1'b0;
  next_cycle();
  read_check("status", REG_STATUS,
             (IO_DATA_W'(1) << ST_BUSY) | (IO_DATA_W'(1) << ST_DONE) |
             (IO_DATA_W'(1) << ST_ERR));
  desc_ready = 1'b1;
  read_check("status", REG_STATUS, (IO_DATA_W'(1) << ST_DONE) | (IO_DATA_W'(1) << ST_ERR));
  apply_reset();
  read_check("status", REG_STATUS, '0);
  read_check("flow_mode", REG_FLOW_MODE, '0);
  // stop also sets done
  bus_write(REG_CTRL, IO_DATA_W'(1) << CTRL_STOP, 4'hf);
  next_cycle();
  read_check("status", REG_STATUS, IO_DATA_W'(1) << ST_DONE);
endtask

`endif

// ==== verification/accel_wrap_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module accel_wrap_tb
  import accel_regs_pkg::*;
  import accel_data_pkg::*;
();

  localparam int WAIT_LIMIT = 20;

  logic                        clk;
  logic                        rst;
  mmio_req_t                   bus;
  mmio_rsp_t                   rsp;
  mem_req_t                    mem_req;
  mem_line_t [HASH_BLOCKS-1:0] rd_b1 = '0;
  mem_line_t [HASH_BLOCKS-1:0] rd_b2 = '0;
  desc_t                       desc_out;
  logic                        desc_valid;
  logic                        desc_ready;
  meta_t                       meta_out;
  logic                        meta_valid;
  logic                        meta_ready;
  match_t                      match;
  logic                        match_release;
  state_t                      state_in;
  logic                        state_in_valid;
  logic                        accel_done;

  integer                seed;
  int                    read_cycles;
  slot_t                 queued_slot [2];
  logic                  mem_s1_en;
  logic [MEM_ADDR_W-1:0] mem_s1_addr;

  accel_wrap UUT (
    .clk            (clk),
    .rst            (rst),
    .bus            (bus),
    .rsp            (rsp),
    .mem_req        (mem_req),
    .rd_b1          (rd_b1),
    .rd_b2          (rd_b2),
    .desc_out       (desc_out),
    .desc_valid     (desc_valid),
    .desc_ready     (desc_ready),
    .meta_out       (meta_out),
    .meta_valid     (meta_valid),
    .meta_ready     (meta_ready),
    .match          (match),
    .match_release  (match_release),
    .state_in       (state_in),
    .state_in_valid (state_in_valid),
    .accel_done     (accel_done)
  );

  always #4 clk = ~clk;

  // one 32-bit word of a hash-table line
  function automatic logic [IO_DATA_W-1:0] model_word(int bank, int blk, int w,
                                                      logic [MEM_ADDR_W-1:0] addr);
    return {4'(bank), 2'(blk), 2'(w), addr, ~addr};
  endfunction

  function automatic mem_line_t model_line(int bank, int blk, logic [MEM_ADDR_W-1:0] addr);
    mem_line_t line;
    for (int w = 0; w < DATA_W / IO_DATA_W; w++) begin
      line[w*IO_DATA_W +: IO_DATA_W] = model_word(bank, blk, w, addr);
    end
    return line;
  endfunction

  // requested bank sits in the upper half and the other bank below it
  function automatic logic [IO_DATA_W-1:0] expected_flow_word(logic bank_req, int blk,
                                                              logic [MEM_ADDR_W-1:0] addr,
                                                              int idx);
    int half_bank;
    if (idx >= 4) begin
      half_bank = bank_req ? 1 : 2;
    end else begin
      half_bank = bank_req ? 2 : 1;
    end
    return model_word(half_bank, blk, idx % 4, addr);
  endfunction

  // two register stages after the enabled edge
  always @(posedge clk) begin
    mem_s1_en   <= mem_req.en;
    mem_s1_addr <= mem_req.addr;
    if (mem_s1_en) begin
      for (int b = 0; b < HASH_BLOCKS; b++) begin
        rd_b1[b] <= model_line(1, b, mem_s1_addr);
        rd_b2[b] <= model_line(2, b, mem_s1_addr);
      end
    end
  end

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic fail_now(string what);
    $display("%s", what);
    stop_on_failure();
  endtask

  task automatic check_word(string name, logic [IO_DATA_W-1:0] got,
                            logic [IO_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_desc(desc_t got, desc_t exp);
    if (got !== exp) begin
      $display("error: desc_out got %h expected %h", got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_meta(meta_t got, meta_t exp);
    if (got !== exp) begin
      $display("error: meta_out got %h expected %h", got, exp);
      stop_on_failure();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  task automatic bus_write(logic [REG_OFF_W-1:0] off, logic [IO_DATA_W-1:0] data,
                           logic [IO_STRB_W-1:0] strb);
    bus.en      = 1'b1;
    bus.wen     = 1'b1;
    bus.strb    = strb;
    bus.addr    = IO_ADDR_W'(off);
    bus.wr_data = data;
    next_cycle();
    bus.en  = 1'b0;
    bus.wen = 1'b0;
  endtask

  // address stays on the bus until rd_valid
  task automatic bus_read(logic [REG_OFF_W-1:0] off, output logic [IO_DATA_W-1:0] data);
    int waited;
    bus.en   = 1'b1;
    bus.wen  = 1'b0;
    bus.addr = IO_ADDR_W'(off);
    next_cycle();
    bus.en = 1'b0;
    waited = 1;
    while (!rsp.rd_valid && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (!rsp.rd_valid) begin
      fail_now($sformatf("read of offset %h got no response", off));
    end
    read_cycles = waited;
    data = rsp.rd_data;
  endtask

  task automatic read_check(string name, logic [REG_OFF_W-1:0] off,
                            logic [IO_DATA_W-1:0] exp);
    logic [IO_DATA_W-1:0] got;
    bus_read(off, got);
    check_word(name, got, exp);
  endtask

  `include "accel_wrap_tests.svh"

  initial begin
    seed           = 32'hf724;
    clk            = 1'b0;
    rst            = 1'b1;
    bus            = '0;
    desc_ready     = 1'b0;
    meta_ready     = 1'b0;
    match          = '0;
    state_in       = '0;
    state_in_valid = 1'b0;
    accel_done     = 1'b0;
    apply_reset();

    test_reset_readback();
    test_command_queue();
    test_match_release();
    test_flow_reads();
    test_status();

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verification
rtl/accel_regs_pkg.sv
rtl/accel_data_pkg.sv
rtl/sync_fifo.sv
rtl/mmio_regs.sv
rtl/job_queue.sv
rtl/flow_table_reader.sv
rtl/accel_wrap.sv
verification/accel_wrap_tb.sv
